// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = x86_front_tb
FILELIST = files.f
SOURCES  = $(shell grep -v '^+' $(FILELIST)) x86_front_model.svh
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== fetch_unit.sv ====
module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  x86_pkg::word_t        cs_i,
  input  x86_pkg::word_t        mem_data_i,
  input  x86_pkg::decode_t      dec_i,
  input  logic                  seq_done_i,
  input  logic                  jump_taken_i,
  output x86_pkg::fetch_state_t state_o,
  output x86_pkg::byte_t        opcode_o,
  output x86_pkg::byte_t        modrm_o,
  output x86_pkg::word_t        disp_o,
  output x86_pkg::word_t        imm_o,
  output x86_pkg::paddr_t       pc_o,
  output x86_pkg::word_t        ip_o
);
  import x86_pkg::*;

  fetch_state_t state;
  fetch_state_t state_next;
  byte_t        opcode_l;
  byte_t        modrm_l;
  word_t        disp_l;
  word_t        imm_l;
  word_t        ip;
  word_t        ip_step;   // bytes consumed or jump offset
  word_t        byte_sext;
  word_t        byte_zext;

  assign byte_sext = {{8{mem_data_i[7]}}, mem_data_i[7:0]};
  assign byte_zext = {8'h00, mem_data_i[7:0]};

  always_comb
  begin
    case (state)
      OPCODE, MODRM: ip_step = 16'd1;
      DISP:          ip_step = dec_i.disp_wide ? 16'd2 : 16'd1;
      IMM:           ip_step = dec_i.imm_wide ? 16'd2 : 16'd1;
      default:       ip_step = jump_taken_i ? imm_l : 16'd0;
    endcase
  end

  // first needed state in order modrm, disp, imm, exec
  always_comb
  begin
    state_next = EXEC;
    case (state)
      OPCODE:
      begin
        if (dec_i.need_modrm)
          state_next = MODRM;
        else if (dec_i.need_disp)
          state_next = DISP;
        else if (dec_i.need_imm)
          state_next = IMM;
      end
      MODRM:
      begin
        if (dec_i.need_disp)
          state_next = DISP;
        else if (dec_i.need_imm)
          state_next = IMM;
      end
      DISP:
      begin
        if (dec_i.need_imm)
          state_next = IMM;
      end
      IMM: state_next = EXEC;
      default:
      begin
        if (seq_done_i)
          state_next = OPCODE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= OPCODE;
      ip    <= '0;
    end
    else
    begin
      state <= state_next;
      ip    <= ip + ip_step;
    end
  end

  always_ff @(posedge clk)
  begin
    case (state)
      OPCODE:
      begin
        opcode_l <= mem_data_i[7:0];
        disp_l   <= '0; // no displacement unless fetched
        imm_l    <= '0;
      end
      MODRM: modrm_l <= mem_data_i[7:0];
      DISP:  disp_l  <= dec_i.disp_wide ? mem_data_i : byte_sext;
      IMM:
      begin
        if (dec_i.imm_wide)
          imm_l <= mem_data_i;
        else if (dec_i.seq == SEQ_JMP)
          imm_l <= byte_sext; // short jump offset
        else
          imm_l <= byte_zext;
      end
      default: ;
    endcase
  end

  // live byte forwarded so decode settles in the same cycle
  assign opcode_o = (state == OPCODE) ? mem_data_i[7:0] : opcode_l;
  assign modrm_o  = (state == MODRM) ? mem_data_i[7:0] : modrm_l;

  assign disp_o  = disp_l;
  assign imm_o   = imm_l;
  assign state_o = state;
  assign ip_o    = ip;
  assign pc_o    = {cs_i, 4'h0} + {4'h0, ip};

endmodule

// ==== files.f ====
+incdir+.
x86_pkg.sv
fetch_unit.sv
opcode_decode.sv
micro_seq.sv
x86_front_top.sv
x86_front_tb.sv

// ==== micro_seq.sv ====
module micro_seq (
  input  logic             clk,
  input  logic             rst,
  input  logic             exec_i,
  input  x86_pkg::decode_t dec_i,
  input  x86_pkg::word_t   disp_i,
  input  x86_pkg::word_t   imm_i,
  output logic             uop_valid_o,
  output x86_pkg::uop_t    uop_o,
  output logic             seq_done_o,
  output logic             jump_taken_o
);
  import x86_pkg::*;

  localparam int STEP_W = $clog2(MAX_STEPS);

  logic [STEP_W-1:0] step;
  logic              second;  // on the final step of a two step sequence
  uop_kind_t         kind;
  logic              last;
  logic              use_imm;

  assign second = (step == STEP_W'(MAX_STEPS - 1));

  always_comb
  begin
    last = 1'b1;
    case (dec_i.seq)
      SEQ_PUSH:
      begin
        kind = second ? UOP_PUSH_ST : UOP_PUSH_DEC;
        last = second;
      end
      SEQ_POP:
      begin
        kind = second ? UOP_POP_INC : UOP_POP_LD;
        last = second;
      end
      SEQ_MOVI:  kind = UOP_MOV_IMM;
      SEQ_MOVRR: kind = UOP_MOV_RR;
      SEQ_MOVRM:
      begin
        kind = second ? UOP_STORE : UOP_EA;
        last = second;
      end
      SEQ_MOVMR:
      begin
        kind = second ? UOP_LOAD : UOP_EA;
        last = second;
      end
      SEQ_JMP:   kind = UOP_JUMP;
      default:   kind = UOP_NOP;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      step <= '0;
    else if (exec_i && !last)
      step <= step + 1'b1;
    else
      step <= '0;
  end

  assign use_imm = (dec_i.seq == SEQ_MOVI) || (dec_i.seq == SEQ_JMP);

  always_comb
  begin
    uop_o.kind  = kind;
    uop_o.last  = last;
    uop_o.wide  = dec_i.wide;
    uop_o.src   = dec_i.src;
    uop_o.dst   = dec_i.dst;
    uop_o.base  = dec_i.base;
    uop_o.index = dec_i.index;
    uop_o.disp  = disp_i;
    uop_o.imm   = use_imm ? imm_i : '0;
  end

  assign uop_valid_o  = exec_i;
  assign seq_done_o   = exec_i && last;
  assign jump_taken_o = exec_i && last && (kind == UOP_JUMP);

endmodule

// ==== opcode_decode.sv ====
module opcode_decode (
  input  x86_pkg::byte_t   opcode_i,
  input  x86_pkg::byte_t   modrm_i,
  output x86_pkg::decode_t dec_o
);
  import x86_pkg::*;

  logic [1:0] mode;
  logic [2:0] regf;
  logic [2:0] rm;
  logic       dir;         // d bit, reg field is destination
  logic       direct;      // mod 0 rm 6
  logic       ea_disp;
  logic       ea_disp_wide;
  reg_sel_t   ea_base;
  reg_sel_t   ea_index;

  assign mode   = modrm_i[7:6];
  assign regf   = modrm_i[5:3];
  assign rm     = modrm_i[2:0];
  assign dir    = opcode_i[1];
  assign direct = (mode == 2'b00) && (rm == 3'd6);

  assign ea_disp      = direct || (mode == 2'b01) || (mode == 2'b10);
  assign ea_disp_wide = direct || (mode == 2'b10);

  always_comb
  begin
    case (rm)
      3'd0:    {ea_base, ea_index} = {REG_BX, REG_SI};
      3'd1:    {ea_base, ea_index} = {REG_BX, REG_DI};
      3'd2:    {ea_base, ea_index} = {REG_BP, REG_SI};
      3'd3:    {ea_base, ea_index} = {REG_BP, REG_DI};
      3'd4:    {ea_base, ea_index} = {REG_NONE, REG_SI};
      3'd5:    {ea_base, ea_index} = {REG_NONE, REG_DI};
      3'd6:    {ea_base, ea_index} = {direct ? REG_NONE : REG_BP, REG_NONE};
      default: {ea_base, ea_index} = {REG_BX, REG_NONE};
    endcase
  end

  always_comb
  begin
    dec_o.seq        = SEQ_NOP;
    dec_o.need_modrm = 1'b0;
    dec_o.need_disp  = 1'b0;
    dec_o.disp_wide  = 1'b0;
    dec_o.need_imm   = 1'b0;
    dec_o.imm_wide   = 1'b0;
    dec_o.wide       = 1'b0;
    dec_o.src        = REG_NONE;
    dec_o.dst        = REG_NONE;
    dec_o.base       = REG_NONE;
    dec_o.index      = REG_NONE;

    casez (opcode_i)
      OP_NOP: dec_o.seq = SEQ_NOP;
      8'b0101_0???: // push reg
      begin
        dec_o.seq  = SEQ_PUSH;
        dec_o.wide = 1'b1;
        dec_o.src  = {1'b0, opcode_i[2:0]};
      end
      8'b0101_1???: // pop reg
      begin
        dec_o.seq  = SEQ_POP;
        dec_o.wide = 1'b1;
        dec_o.dst  = {1'b0, opcode_i[2:0]};
      end
      8'b1011_????: // mov imm to reg, bit 3 is word
      begin
        dec_o.seq      = SEQ_MOVI;
        dec_o.need_imm = 1'b1;
        dec_o.imm_wide = opcode_i[3];
        dec_o.wide     = opcode_i[3];
        dec_o.dst      = {1'b0, opcode_i[2:0]};
      end
      8'b1000_10??: // mov r/m
      begin
        dec_o.need_modrm = 1'b1;
        dec_o.wide       = opcode_i[0];
        if (mode == 2'b11)
        begin
          dec_o.seq = SEQ_MOVRR;
          dec_o.dst = {1'b0, dir ? regf : rm};
          dec_o.src = {1'b0, dir ? rm : regf};
        end
        else
        begin
          dec_o.seq       = dir ? SEQ_MOVMR : SEQ_MOVRM;
          dec_o.need_disp = ea_disp;
          dec_o.disp_wide = ea_disp_wide;
          dec_o.base      = ea_base;
          dec_o.index     = ea_index;
          if (dir)
            dec_o.dst = {1'b0, regf};
          else
            dec_o.src = {1'b0, regf};
        end
      end
      OP_JMP_SHORT, OP_JMP_NEAR:
      begin
        dec_o.seq      = SEQ_JMP;
        dec_o.need_imm = 1'b1;
        dec_o.imm_wide = ~opcode_i[1]; // e9 carries 16 bits
        dec_o.wide     = 1'b1;
      end
      default: ; // unlisted opcode runs as nop
    endcase
  end

endmodule

// ==== x86_front_model.svh ====
`ifndef X86_FRONT_MODEL_SVH
`define X86_FRONT_MODEL_SVH

logic [7:0]  mem [0:(1 << 20) - 1];
logic [31:0] rng;
word_t       cs_val;
word_t       model_ip;
uop_t        exp_uop [2];
int unsigned exp_count;
int unsigned exp_latency;   // opcode cycle to first strobe

function automatic logic [31:0] rand_next();
  rng = rng ^ (rng << 13);
  rng = rng ^ (rng >> 17);
  rng = rng ^ (rng << 5);
  return rng;
endfunction

// segment times 16 plus offset, kept to 20 bits
function automatic paddr_t phys_addr(word_t ip);
  return paddr_t'(cs_val) * 20'd16 + paddr_t'(ip);
endfunction

// physical read, pc plus k wraps in 20 bits like the bus
function automatic byte_t mem_at(word_t ip, int unsigned k);
  paddr_t a;
  a = phys_addr(ip) + paddr_t'(k);
  return mem[a];
endfunction

task automatic put_byte(inout int unsigned addr, input byte_t value);
  if (addr < (1 << 20))
    mem[addr[19:0]] = value;
  addr = addr + 1;
endtask

task automatic gen_program();
  int unsigned addr;
  logic [31:0] r;
  addr = 0;
  while (addr < (1 << 20))
  begin
    r = rand_next();
    case (r[3:0])
      4'd0, 4'd1: put_byte(addr, OP_NOP);
      4'd2, 4'd3, 4'd4: put_byte(addr, {4'h5, r[7:4]}); // push or pop
      4'd5, 4'd6:
      begin
        put_byte(addr, {4'hb, r[7:4]});
        put_byte(addr, r[15:8]);
        put_byte(addr, r[23:16]);
      end
      4'd7, 4'd8, 4'd9, 4'd10:
      begin
        put_byte(addr, {6'b100010, r[5:4]});
        put_byte(addr, r[15:8]); // modrm
        put_byte(addr, r[23:16]);
        put_byte(addr, r[31:24]);
      end
      4'd11:
      begin
        put_byte(addr, r[4] ? OP_JMP_SHORT : OP_JMP_NEAR);
        put_byte(addr, r[15:8]);
        put_byte(addr, r[23:16]);
      end
      default: put_byte(addr, r[11:4]); // mostly unlisted
    endcase
  end
endtask

task automatic set_seq(input uop_t u, input uop_kind_t k0, input uop_kind_t k1,
                       input int unsigned n);
  exp_count = n;
  exp_uop[0] = u;
  exp_uop[0].kind = k0;
  exp_uop[0].last = (n == 1);
  exp_uop[1] = u;
  exp_uop[1].kind = k1;
  exp_uop[1].last = 1'b1;
endtask

// walks one instruction at model_ip
task automatic predict_instr();
  byte_t      op;
  byte_t      mrm;
  byte_t      b;
  word_t      ip;
  logic [1:0] md;
  logic [2:0] rf;
  logic [2:0] rm;
  uop_t       u;
  ip = model_ip;
  op = mem_at(ip, 0);
  ip = ip + 16'd1;
  exp_latency = 1;
  u = '0;
  u.src = REG_NONE;
  u.dst = REG_NONE;
  u.base = REG_NONE;
  u.index = REG_NONE;
  if (op[7:4] == 4'h5)
  begin
    u.wide = 1'b1;
    if (op[3])
    begin
      u.dst = {1'b0, op[2:0]};
      set_seq(u, UOP_POP_LD, UOP_POP_INC, 2);
    end
    else
    begin
      u.src = {1'b0, op[2:0]};
      set_seq(u, UOP_PUSH_DEC, UOP_PUSH_ST, 2);
    end
  end
  else if (op[7:4] == 4'hb)
  begin
    u.wide = op[3];
    u.dst = {1'b0, op[2:0]};
    u.imm = op[3] ? {mem_at(ip, 1), mem_at(ip, 0)} : {8'h00, mem_at(ip, 0)};
    ip = ip + (op[3] ? 16'd2 : 16'd1);
    exp_latency++;
    set_seq(u, UOP_MOV_IMM, UOP_NOP, 1);
  end
  else if (op[7:2] == 6'b100010)
  begin
    mrm = mem_at(ip, 0);
    ip = ip + 16'd1;
    exp_latency++;
    md = mrm[7:6];
    rf = mrm[5:3];
    rm = mrm[2:0];
    u.wide = op[0];
    if (md == 2'b11)
    begin
      u.dst = {1'b0, op[1] ? rf : rm};
      u.src = {1'b0, op[1] ? rm : rf};
      set_seq(u, UOP_MOV_RR, UOP_NOP, 1);
    end
    else
    begin
      case (rm)
        3'd0: {u.base, u.index} = {REG_BX, REG_SI};
        3'd1: {u.base, u.index} = {REG_BX, REG_DI};
        3'd2: {u.base, u.index} = {REG_BP, REG_SI};
        3'd3: {u.base, u.index} = {REG_BP, REG_DI};
        3'd4: {u.base, u.index} = {REG_NONE, REG_SI};
        3'd5: {u.base, u.index} = {REG_NONE, REG_DI};
        3'd6: {u.base, u.index} = {(md == 2'b00) ? REG_NONE : REG_BP, REG_NONE};
        default: {u.base, u.index} = {REG_BX, REG_NONE};
      endcase
      if (md == 2'b10 || (md == 2'b00 && rm == 3'd6))
      begin
        u.disp = {mem_at(ip, 1), mem_at(ip, 0)};
        ip = ip + 16'd2;
        exp_latency++;
      end
      else if (md == 2'b01)
      begin
        b = mem_at(ip, 0);
        u.disp = {{8{b[7]}}, b};
        ip = ip + 16'd1;
        exp_latency++;
      end
      if (op[1])
      begin
        u.dst = {1'b0, rf};
        set_seq(u, UOP_EA, UOP_LOAD, 2);
      end
      else
      begin
        u.src = {1'b0, rf};
        set_seq(u, UOP_EA, UOP_STORE, 2);
      end
    end
  end
  else if (op == OP_JMP_SHORT || op == OP_JMP_NEAR)
  begin
    u.wide = 1'b1;
    if (op == OP_JMP_NEAR)
    begin
      u.imm = {mem_at(ip, 1), mem_at(ip, 0)};
      ip = ip + 16'd2;
    end
    else
    begin
      b = mem_at(ip, 0);
      u.imm = {{8{b[7]}}, b};
      ip = ip + 16'd1;
    end
    exp_latency++;
    ip = ip + u.imm; // target relative to next instruction
    set_seq(u, UOP_JUMP, UOP_NOP, 1);
  end
  else
    set_seq(u, UOP_NOP, UOP_NOP, 1); // nop and anything unlisted
  model_ip = ip;
endtask

`endif

// ==== x86_front_tb.sv ====
module x86_front_tb;
  import x86_pkg::*;

  localparam int NUM_INSTR  = 800;
  localparam int WAIT_LIMIT = 8;  // cycles, longest fetch is 4

  logic   clk;
  logic   rst;
  word_t  cs_i;
  word_t  mem_data_i;
  paddr_t pc_o;
  logic   uop_valid_o;
  uop_t   uop_o;
  word_t  ip_o;

  `include "x86_front_model.svh"

  x86_front_top x86_front_top_inst (
    .clk         (clk),
    .rst         (rst),
    .cs_i        (cs_i),
    .mem_data_i  (mem_data_i),
    .pc_o        (pc_o),
    .uop_valid_o (uop_valid_o),
    .uop_o       (uop_o),
    .ip_o        (ip_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // same cycle memory, two bytes from pc
  always @(negedge clk)
    mem_data_i <= {mem[pc_o + 20'd1], mem[pc_o]};

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at time %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("ERROR at time %0t: %s", $time, why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  initial
  begin
    int unsigned lat;
    logic [31:0] r;
    rst = 1'b1;
    mem_data_i = '0;
    rng = 32'hdb97_1327;
    r = rand_next();
    cs_val = r[15:0];
    cs_i = cs_val;
    gen_program();

    repeat (2)
    begin
      @(negedge clk);
      check_value(64'(uop_valid_o), 64'(0), "strobe during reset");
    end
    rst = 1'b0;
    model_ip = '0;
    check_value(64'(ip_o), 64'(0), "ip after reset");

    for (int n = 0; n < NUM_INSTR; n++)
    begin
      // opcode cycle
      check_value(64'(ip_o), 64'(model_ip), "ip at opcode fetch");
      check_value(64'(pc_o), 64'(phys_addr(model_ip)), "pc at opcode fetch");
      check_value(64'(uop_valid_o), 64'(0), "strobe in opcode cycle");
      predict_instr();
      lat = 0;
      do
      begin
        @(negedge clk);
        lat++;
      end
      while (!uop_valid_o && lat < WAIT_LIMIT);
      if (!uop_valid_o)
        fail_run("no micro-op strobe arrived after the opcode fetch");
      check_value(64'(lat), 64'(exp_latency), "latency to first strobe");
      for (int i = 0; i < int'(exp_count); i++)
      begin
        if (i > 0)
          @(negedge clk);
        check_value(64'(uop_valid_o), 64'(1), "strobe during sequence");
        check_value(64'(uop_o), 64'(exp_uop[i]), "micro-op");
      end
      @(negedge clk);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== x86_front_top.sv ====
module x86_front_top (
  input  logic            clk,
  input  logic            rst,
  input  x86_pkg::word_t  cs_i,
  input  x86_pkg::word_t  mem_data_i,
  output x86_pkg::paddr_t pc_o,
  output logic            uop_valid_o,
  output x86_pkg::uop_t   uop_o,
  output x86_pkg::word_t  ip_o
);
  import x86_pkg::*;

  fetch_state_t fetch_state;
  byte_t        opcode;
  byte_t        modrm;
  word_t        disp;
  word_t        imm;
  decode_t      dec;
  logic         exec;
  logic         seq_done;
  logic         jump_taken;

  assign exec = (fetch_state == EXEC);

  fetch_unit fetch_unit_inst (
    .clk          (clk),
    .rst          (rst),
    .cs_i         (cs_i),
    .mem_data_i   (mem_data_i),
    .dec_i        (dec),
    .seq_done_i   (seq_done),
    .jump_taken_i (jump_taken),
    .state_o      (fetch_state),
    .opcode_o     (opcode),
    .modrm_o      (modrm),
    .disp_o       (disp),
    .imm_o        (imm),
    .pc_o         (pc_o),
    .ip_o         (ip_o)
  );

  opcode_decode opcode_decode_inst (
    .opcode_i (opcode),
    .modrm_i  (modrm),
    .dec_o    (dec)
  );

  micro_seq micro_seq_inst (
    .clk          (clk),
    .rst          (rst),
    .exec_i       (exec),
    .dec_i        (dec),
    .disp_i       (disp),
    .imm_i        (imm),
    .uop_valid_o  (uop_valid_o),
    .uop_o        (uop_o),
    .seq_done_o   (seq_done),
    .jump_taken_o (jump_taken)
  );

endmodule

// ==== x86_pkg.sv ====
package x86_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [19:0] paddr_t;
  typedef logic [3:0]  reg_sel_t;

  typedef enum logic [2:0] {
    OPCODE,
    MODRM,
    DISP,
    IMM,
    EXEC
  } fetch_state_t;

  typedef enum logic [3:0] {
    UOP_NOP,
    UOP_PUSH_DEC,
    UOP_PUSH_ST,
    UOP_POP_LD,
    UOP_POP_INC,
    UOP_MOV_IMM,
    UOP_MOV_RR,
    UOP_EA,
    UOP_STORE,
    UOP_LOAD,
    UOP_JUMP
  } uop_kind_t;

  typedef enum logic [2:0] {
    SEQ_NOP,
    SEQ_PUSH,
    SEQ_POP,
    SEQ_MOVI,
    SEQ_MOVRR,
    SEQ_MOVRM,
    SEQ_MOVMR,
    SEQ_JMP
  } seq_t;

  typedef struct packed {
    seq_t     seq;
    logic     need_modrm;
    logic     need_disp;
    logic     disp_wide;
    logic     need_imm;
    logic     imm_wide;
    logic     wide;       // word operation
    reg_sel_t src;
    reg_sel_t dst;
    reg_sel_t base;
    reg_sel_t index;
  } decode_t;

  typedef struct packed {
    uop_kind_t kind;
    logic      last;
    logic      wide;
    reg_sel_t  src;
    reg_sel_t  dst;
    reg_sel_t  base;
    reg_sel_t  index;
    word_t     disp;
    word_t     imm;
  } uop_t;

  localparam byte_t OP_NOP       = 8'h90;
  localparam byte_t OP_JMP_SHORT = 8'heb;
  localparam byte_t OP_JMP_NEAR  = 8'he9;

  localparam int MAX_STEPS = 2; // longest sequence

  localparam reg_sel_t REG_BX   = 4'd3;
  localparam reg_sel_t REG_BP   = 4'd5;
  localparam reg_sel_t REG_SI   = 4'd6;
  localparam reg_sel_t REG_DI   = 4'd7;
  localparam reg_sel_t REG_NONE = 4'd12;

endpackage
